// ==== kme_pkg.sv ====
package kme_pkg;

  // ------------------------------------------------------------------------
  // Sizing constants
  // ------------------------------------------------------------------------

  // Width of one frame data word
  localparam int KME_DATA_W = 64;

  // Type code carried in every key frame header
  localparam logic [7:0] KME_TLV_KEY_TYPE = 8'h04;

  // A 256-bit key is split into four 64-bit words
  localparam int KME_KEY_WORDS = 4;
  // Header word plus the key words
  localparam int KME_FRAME_WORDS = KME_KEY_WORDS + 1;

  // Key context memory geometry
  localparam int KME_KEY_SLOTS = 16;
  localparam int KME_CKV_DEPTH = KME_KEY_SLOTS * KME_KEY_WORDS;
  localparam int KME_CKV_AW = $clog2(KME_CKV_DEPTH);
  // Slot index forms the upper address bits
  localparam int KME_SLOT_AW = $clog2(KME_KEY_SLOTS);
  // Word within a slot forms the lower address bits
  localparam int KME_WORD_AW = $clog2(KME_KEY_WORDS);

  // Engine input FIFO geometry
  localparam int KME_FIFO_DEPTH = 8;
  localparam int KME_FIFO_AW = $clog2(KME_FIFO_DEPTH);

  // ------------------------------------------------------------------------
  // Frame word types
  // ------------------------------------------------------------------------

  // One word on the internal stream
  typedef struct packed {
    logic [KME_DATA_W-1:0] tdata;
    // Marks the last word of a frame
    logic                  eot;
  } kme_internal_t;

  // Layout of tdata in the header word
  typedef struct packed {
    logic [7:0]  tlv_type;
    // Bit 2 selects decrypt over encrypt/validate
    logic [3:0]  tlv_eng_id;
    logic [7:0]  tlv_key_index;
    // Number of words in the frame, header included
    logic [7:0]  tlv_len;
    logic [35:0] reserved;
  } kme_internal_word_0_t;

endpackage

// ==== kme_ckv_ram.sv ====
`timescale 1ns/1ps

module kme_ckv_ram (
  input  logic                          clk,
  // Host write port
  input  logic                          wr,
  input  logic [kme_pkg::KME_CKV_AW-1:0] wr_addr,
  input  logic [kme_pkg::KME_DATA_W-1:0] wr_data,
  // Reader port
  input  logic [kme_pkg::KME_CKV_AW-1:0] rd_addr,
  output logic [kme_pkg::KME_DATA_W-1:0] rd_data
);

  import kme_pkg::*;

  // ------------------------------------------------------------------------
  // Storage
  // ------------------------------------------------------------------------

  // One row per 64-bit key word
  // Slot s occupies rows 4*s to 4*s+3
  logic [KME_DATA_W-1:0] mem [KME_CKV_DEPTH];

  // Host writes land at the clock edge
  always_ff @(posedge clk) begin
    if (wr) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // ------------------------------------------------------------------------
  // Registered read
  // ------------------------------------------------------------------------

  // Data shows up one cycle after the address
  // Holding the address keeps the same word on rd_data
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

// ==== kme_ckv_reader.sv ====
`timescale 1ns/1ps

module kme_ckv_reader (
  input  logic                           clk,
  input  logic                           rst_n,
  // Host command strobe
  input  logic                           cmd_valid,
  input  logic [3:0]                     cmd_eng_id,
  input  logic [3:0]                     cmd_key_index,
  output logic                           busy,
  // Key context memory read port
  output logic [kme_pkg::KME_CKV_AW-1:0] ram_rd_addr,
  input  logic [kme_pkg::KME_DATA_W-1:0] ram_rd_data,
  // Stream toward the assigner
  output logic                           ckvreader_kopassigner_valid,
  output kme_pkg::kme_internal_t         ckvreader_kopassigner_data,
  input  logic                           kopassigner_ckvreader_ack
);

  import kme_pkg::*;

  // Slot of the command in flight
  logic [KME_SLOT_AW-1:0] slot_q;
  // Key words already loaded into the output register
  logic [KME_WORD_AW:0]   key_cnt;
  logic [KME_WORD_AW:0]   key_cnt_nxt;
  logic                   take_cmd;
  logic                   word_moved;
  logic                   load_key;
  logic                   last_key;
  kme_internal_word_0_t   hdr;

  // ------------------------------------------------------------------------
  // Command decode and header build
  // ------------------------------------------------------------------------

  // Commands are only taken while idle
  assign take_cmd = cmd_valid && !busy;

  always_comb begin
    hdr               = '0;
    hdr.tlv_type      = KME_TLV_KEY_TYPE;
    hdr.tlv_eng_id    = cmd_eng_id;
    // Slot index zero extended into the 8-bit field
    hdr.tlv_key_index = 8'(cmd_key_index);
    hdr.tlv_len       = 8'(KME_FRAME_WORDS);
  end

  // ------------------------------------------------------------------------
  // Key word prefetch
  // ------------------------------------------------------------------------

  // Handshake on the output word
  assign word_moved = ckvreader_kopassigner_valid && kopassigner_ckvreader_ack;
  // Every acked word except eot pulls in the next key word
  assign load_key   = word_moved && !ckvreader_kopassigner_data.eot;
  // The fourth key word closes the frame
  assign last_key   = (key_cnt == (KME_WORD_AW + 1)'(KME_KEY_WORDS - 1));

  assign key_cnt_nxt = load_key ? key_cnt + 1'b1 : key_cnt;

  // Address always points at the word to be loaded next
  // So ram_rd_data is already valid when the current word is acked
  // While idle the address tracks the incoming command for key word 0
  always_comb begin
    if (busy) begin
      ram_rd_addr = {slot_q, key_cnt_nxt[KME_WORD_AW-1:0]};
    end else begin
      ram_rd_addr = {cmd_key_index, {KME_WORD_AW{1'b0}}};
    end
  end

  // ------------------------------------------------------------------------
  // Control state
  // ------------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy                        <= 1'b0;
      ckvreader_kopassigner_valid <= 1'b0;
      slot_q                      <= '0;
      key_cnt                     <= '0;
    end else if (take_cmd) begin
      // Header goes out the next cycle
      busy                        <= 1'b1;
      ckvreader_kopassigner_valid <= 1'b1;
      slot_q                      <= cmd_key_index;
      key_cnt                     <= '0;
    end else begin
      // Frame done once eot is acked
      if (word_moved && ckvreader_kopassigner_data.eot) begin
        busy                        <= 1'b0;
        ckvreader_kopassigner_valid <= 1'b0;
      end
      key_cnt <= key_cnt_nxt;
    end
  end

  // ------------------------------------------------------------------------
  // Output holding register
  // ------------------------------------------------------------------------

  // Contents only change on a new command or an acked word
  always_ff @(posedge clk) begin
    if (take_cmd) begin
      ckvreader_kopassigner_data <= '{tdata: hdr, eot: 1'b0};
    end else if (load_key) begin
      ckvreader_kopassigner_data <= '{tdata: ram_rd_data, eot: last_key};
    end
  end

endmodule

// ==== kme_kop_assigner.sv ====
`timescale 1ns/1ps

module kme_kop_assigner (
  input  logic                   clk,
  input  logic                   rst_n,
  // Reader stream
  input  logic                   ckvreader_kopassigner_valid,
  input  kme_pkg::kme_internal_t ckvreader_kopassigner_data,
  output logic                   kopassigner_ckvreader_ack,
  // Encrypt engine FIFO
  output kme_pkg::kme_internal_t encrypt_in,
  output logic                   encrypt_in_valid,
  input  logic                   encrypt_in_stall,
  // Validate engine FIFO
  output kme_pkg::kme_internal_t validate_in,
  output logic                   validate_in_valid,
  input  logic                   validate_in_stall,
  // Decrypt engine FIFO
  output kme_pkg::kme_internal_t decrypt_in,
  output logic                   decrypt_in_valid,
  input  logic                   decrypt_in_stall
);

  import kme_pkg::*;

  typedef enum logic [1:0] {
    ST_HEADER  = 2'd0,
    ST_ENC_VAL = 2'd1,
    ST_DECRYPT = 2'd2
  } kop_state_t;

  kop_state_t           cur_state;
  kop_state_t           nxt_state;
  kme_internal_word_0_t tlv_word0;
  logic                 to_decrypt;
  logic                 ev_go;
  logic                 dec_go;

  // ------------------------------------------------------------------------
  // Path selection
  // ------------------------------------------------------------------------

  // Header view of the incoming word
  assign tlv_word0 = ckvreader_kopassigner_data.tdata;

  // Header words are decoded and the rest follow the state
  always_comb begin
    case (cur_state)
      ST_ENC_VAL: to_decrypt = 1'b0;
      ST_DECRYPT: to_decrypt = 1'b1;
      default:    to_decrypt = tlv_word0.tlv_eng_id[2];
    endcase
  end

  // Paired path needs room in both FIFOs
  assign ev_go  = ckvreader_kopassigner_valid && !to_decrypt &&
                  !encrypt_in_stall && !validate_in_stall;
  assign dec_go = ckvreader_kopassigner_valid && to_decrypt && !decrypt_in_stall;

  // ------------------------------------------------------------------------
  // Dispatch
  // ------------------------------------------------------------------------

  // Ack is the push and depends on the current stall only
  assign kopassigner_ckvreader_ack = ev_go || dec_go;

  assign encrypt_in_valid  = ev_go;
  assign validate_in_valid = ev_go;
  assign decrypt_in_valid  = dec_go;

  // Idle outputs are driven to zero
  assign encrypt_in  = ev_go  ? ckvreader_kopassigner_data : '0;
  assign validate_in = ev_go  ? ckvreader_kopassigner_data : '0;
  assign decrypt_in  = dec_go ? ckvreader_kopassigner_data : '0;

  // ------------------------------------------------------------------------
  // Frame state
  // ------------------------------------------------------------------------

  always_comb begin
    nxt_state = cur_state;
    case (cur_state)
      ST_HEADER: begin
        // Lock onto the chosen path once the header moves
        if (ev_go && !ckvreader_kopassigner_data.eot) begin
          nxt_state = ST_ENC_VAL;
        end else if (dec_go && !ckvreader_kopassigner_data.eot) begin
          nxt_state = ST_DECRYPT;
        end
      end
      ST_ENC_VAL: begin
        if (ev_go && ckvreader_kopassigner_data.eot) begin
          nxt_state = ST_HEADER;
        end
      end
      ST_DECRYPT: begin
        if (dec_go && ckvreader_kopassigner_data.eot) begin
          nxt_state = ST_HEADER;
        end
      end
      default: nxt_state = ST_HEADER;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cur_state <= ST_HEADER;
    end else begin
      cur_state <= nxt_state;
    end
  end

endmodule

// ==== kme_engine_fifo.sv ====
`timescale 1ns/1ps

module kme_engine_fifo (
  input  logic                   clk,
  input  logic                   rst_n,
  // Write side from the assigner
  input  logic                   push,
  input  kme_pkg::kme_internal_t push_data,
  output logic                   full,
  // Read side toward the engine
  input  logic                   pop,
  output kme_pkg::kme_internal_t head_data,
  output logic                   empty
);

  import kme_pkg::*;

  kme_internal_t          mem [KME_FIFO_DEPTH];
  logic [KME_FIFO_AW-1:0] wr_ptr;
  logic [KME_FIFO_AW-1:0] rd_ptr;
  // One extra bit so that a full FIFO is counted
  logic [KME_FIFO_AW:0]   count;
  logic                   do_push;
  logic                   do_pop;

  // ------------------------------------------------------------------------
  // Levels
  // ------------------------------------------------------------------------

  assign full  = (count == (KME_FIFO_AW + 1)'(KME_FIFO_DEPTH));
  assign empty = (count == '0);

  // Guard against overflow and underflow
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  // Head word is read straight from the array
  assign head_data = mem[rd_ptr];

  // ------------------------------------------------------------------------
  // Storage
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // ------------------------------------------------------------------------
  // Pointers and occupancy
  // ------------------------------------------------------------------------

  // Depth is a power of two so pointers wrap on their own
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves the count unchanged
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// ==== kme_core.sv ====
`timescale 1ns/1ps

module kme_core (
  input  logic                           clk,
  input  logic                           rst_n,
  // Host key load
  input  logic                           key_wr,
  input  logic [kme_pkg::KME_CKV_AW-1:0] key_wr_addr,
  input  logic [kme_pkg::KME_DATA_W-1:0] key_wr_data,
  // Host commands
  input  logic                           cmd_valid,
  input  logic [3:0]                     cmd_eng_id,
  input  logic [3:0]                     cmd_key_index,
  output logic                           busy,
  // Encrypt engine
  input  logic                           encrypt_pop,
  output logic                           encrypt_empty,
  output kme_pkg::kme_internal_t         encrypt_data,
  // Validate engine
  input  logic                           validate_pop,
  output logic                           validate_empty,
  output kme_pkg::kme_internal_t         validate_data,
  // Decrypt engine
  input  logic                           decrypt_pop,
  output logic                           decrypt_empty,
  output kme_pkg::kme_internal_t         decrypt_data
);

  import kme_pkg::*;

  // Memory read port
  logic [KME_CKV_AW-1:0] ram_rd_addr;
  logic [KME_DATA_W-1:0] ram_rd_data;
  // Reader to assigner stream
  logic                  ckvreader_kopassigner_valid;
  kme_internal_t         ckvreader_kopassigner_data;
  logic                  kopassigner_ckvreader_ack;
  // Assigner to FIFO pushes and stalls
  kme_internal_t         encrypt_in;
  logic                  encrypt_in_valid;
  logic                  encrypt_in_stall;
  kme_internal_t         validate_in;
  logic                  validate_in_valid;
  logic                  validate_in_stall;
  kme_internal_t         decrypt_in;
  logic                  decrypt_in_valid;
  logic                  decrypt_in_stall;

  // ------------------------------------------------------------------------
  // Key context and reader
  // ------------------------------------------------------------------------

  kme_ckv_ram u_ckv_ram (
    .clk     (clk),
    .wr      (key_wr),
    .wr_addr (key_wr_addr),
    .wr_data (key_wr_data),
    .rd_addr (ram_rd_addr),
    .rd_data (ram_rd_data)
  );

  kme_ckv_reader u_ckv_reader (
    .clk                         (clk),
    .rst_n                       (rst_n),
    .cmd_valid                   (cmd_valid),
    .cmd_eng_id                  (cmd_eng_id),
    .cmd_key_index               (cmd_key_index),
    .busy                        (busy),
    .ram_rd_addr                 (ram_rd_addr),
    .ram_rd_data                 (ram_rd_data),
    .ckvreader_kopassigner_valid (ckvreader_kopassigner_valid),
    .ckvreader_kopassigner_data  (ckvreader_kopassigner_data),
    .kopassigner_ckvreader_ack   (kopassigner_ckvreader_ack)
  );

  // ------------------------------------------------------------------------
  // Frame steering
  // ------------------------------------------------------------------------

  kme_kop_assigner u_kop_assigner (
    .clk                         (clk),
    .rst_n                       (rst_n),
    .ckvreader_kopassigner_valid (ckvreader_kopassigner_valid),
    .ckvreader_kopassigner_data  (ckvreader_kopassigner_data),
    .kopassigner_ckvreader_ack   (kopassigner_ckvreader_ack),
    .encrypt_in                  (encrypt_in),
    .encrypt_in_valid            (encrypt_in_valid),
    .encrypt_in_stall            (encrypt_in_stall),
    .validate_in                 (validate_in),
    .validate_in_valid           (validate_in_valid),
    .validate_in_stall           (validate_in_stall),
    .decrypt_in                  (decrypt_in),
    .decrypt_in_valid            (decrypt_in_valid),
    .decrypt_in_stall            (decrypt_in_stall)
  );

  // ------------------------------------------------------------------------
  // Engine input FIFOs
  // ------------------------------------------------------------------------

  // Full level doubles as the stall back to the assigner
  kme_engine_fifo u_encrypt_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (encrypt_in_valid),
    .push_data (encrypt_in),
    .full      (encrypt_in_stall),
    .pop       (encrypt_pop),
    .head_data (encrypt_data),
    .empty     (encrypt_empty)
  );

  kme_engine_fifo u_validate_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (validate_in_valid),
    .push_data (validate_in),
    .full      (validate_in_stall),
    .pop       (validate_pop),
    .head_data (validate_data),
    .empty     (validate_empty)
  );

  kme_engine_fifo u_decrypt_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (decrypt_in_valid),
    .push_data (decrypt_in),
    .full      (decrypt_in_stall),
    .pop       (decrypt_pop),
    .head_data (decrypt_data),
    .empty     (decrypt_empty)
  );

endmodule

// ==== kme_core_assert.sv ====
`timescale 1ns/1ps

module kme_core_assert (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   ckvreader_kopassigner_valid,
  input kme_pkg::kme_internal_t ckvreader_kopassigner_data,
  input logic                   kopassigner_ckvreader_ack,
  input logic                   encrypt_in_valid,
  input logic                   validate_in_valid,
  input logic                   decrypt_in_valid,
  input logic                   encrypt_in_stall,
  input logic                   validate_in_stall,
  input logic                   decrypt_in_stall
);

  // Failures seen so far, read by the testbench at the end
  int fail_cnt = 0;

  // ------------------------------------------------------------------------
  // Path exclusivity
  // ------------------------------------------------------------------------

  // Encrypt and validate always receive the same words
  pair_same_a: assert property (@(posedge clk) disable iff (!rst_n)
    encrypt_in_valid == validate_in_valid)
    else begin
      $error("encrypt_in_valid=%h validate_in_valid=%h differ",
             encrypt_in_valid, validate_in_valid);
      fail_cnt = fail_cnt + 1;
    end

  dec_excl_a: assert property (@(posedge clk) disable iff (!rst_n)
    !(decrypt_in_valid && encrypt_in_valid))
    else begin
      $error("decrypt_in_valid and encrypt_in_valid high together");
      fail_cnt = fail_cnt + 1;
    end

  // An acked word goes down exactly one path
  ack_one_a: assert property (@(posedge clk) disable iff (!rst_n)
    kopassigner_ckvreader_ack |-> (encrypt_in_valid != decrypt_in_valid))
    else begin
      $error("ack high with encrypt_in_valid=%h decrypt_in_valid=%h",
             encrypt_in_valid, decrypt_in_valid);
      fail_cnt = fail_cnt + 1;
    end

  // ------------------------------------------------------------------------
  // Back-pressure
  // ------------------------------------------------------------------------

  no_push_full_a: assert property (@(posedge clk) disable iff (!rst_n)
    !(encrypt_in_valid && encrypt_in_stall) && !(validate_in_valid && validate_in_stall) &&
    !(decrypt_in_valid && decrypt_in_stall))
    else begin
      $error("push into a stalled FIFO");
      fail_cnt = fail_cnt + 1;
    end

  // Reader holds its word until it is acked
  hold_word_a: assert property (@(posedge clk) disable iff (!rst_n)
    (ckvreader_kopassigner_valid && !kopassigner_ckvreader_ack) |=>
    (ckvreader_kopassigner_valid && $stable(ckvreader_kopassigner_data)))
    else begin
      $error("reader word changed before ack, data now %h", ckvreader_kopassigner_data);
      fail_cnt = fail_cnt + 1;
    end

endmodule

bind kme_kop_assigner kme_core_assert u_kop_assert (
  .clk                         (clk),
  .rst_n                       (rst_n),
  .ckvreader_kopassigner_valid (ckvreader_kopassigner_valid),
  .ckvreader_kopassigner_data  (ckvreader_kopassigner_data),
  .kopassigner_ckvreader_ack   (kopassigner_ckvreader_ack),
  .encrypt_in_valid            (encrypt_in_valid),
  .validate_in_valid           (validate_in_valid),
  .decrypt_in_valid            (decrypt_in_valid),
  .encrypt_in_stall            (encrypt_in_stall),
  .validate_in_stall           (validate_in_stall),
  .decrypt_in_stall            (decrypt_in_stall)
);

// ==== tb_kme_core.sv ====
`timescale 1ns/1ps

module tb_kme_core;

  import kme_pkg::*;

  localparam logic [31:0] SEED = 32'h27b021bb;
  localparam int CLK_HALF    = 4;
  localparam int IDLE_LIMIT  = 200;
  localparam int DRAIN_LIMIT = 2000;
  localparam int HOLD_CYCLES = 40;
  localparam int RANDOM_CMDS = 40;

  logic                  clk;
  logic                  rst_n;
  logic                  key_wr;
  logic [KME_CKV_AW-1:0] key_wr_addr;
  logic [KME_DATA_W-1:0] key_wr_data;
  logic                  cmd_valid;
  logic [3:0]            cmd_eng_id;
  logic [3:0]            cmd_key_index;
  logic                  busy;
  // Engine side, pops are owned by the monitor block
  logic                  encrypt_pop = 1'b0;
  logic                  encrypt_empty;
  kme_internal_t         encrypt_data;
  logic                  validate_pop = 1'b0;
  logic                  validate_empty;
  kme_internal_t         validate_data;
  logic                  decrypt_pop = 1'b0;
  logic                  decrypt_empty;
  kme_internal_t         decrypt_data;

  // Mirror of the key context memory
  logic [KME_DATA_W-1:0] key_mirror [KME_CKV_DEPTH];
  // Expected words per engine, {tdata, eot}
  logic [64:0]           enc_q[$];
  logic [64:0]           val_q[$];
  logic [64:0]           dec_q[$];
  logic [31:0]           rng_state;
  // Separate generator for the pop patterns
  logic [31:0]           pop_rng = ~SEED;
  // 0 no pops, 1 pop every cycle, 2 random pops
  logic [1:0]            pop_mode = 2'd0;
  int                    mon_err_cnt = 0;
  int                    seq_err_cnt = 0;

  kme_core kme_core_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .key_wr         (key_wr),
    .key_wr_addr    (key_wr_addr),
    .key_wr_data    (key_wr_data),
    .cmd_valid      (cmd_valid),
    .cmd_eng_id     (cmd_eng_id),
    .cmd_key_index  (cmd_key_index),
    .busy           (busy),
    .encrypt_pop    (encrypt_pop),
    .encrypt_empty  (encrypt_empty),
    .encrypt_data   (encrypt_data),
    .validate_pop   (validate_pop),
    .validate_empty (validate_empty),
    .validate_data  (validate_data),
    .decrypt_pop    (decrypt_pop),
    .decrypt_empty  (decrypt_empty),
    .decrypt_data   (decrypt_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_HALF) clk = ~clk;
  end

  // ------------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Idle once the reader is done and every expected word has been popped
  function automatic logic all_idle();
    return !busy && encrypt_empty && validate_empty && decrypt_empty &&
           enc_q.size() == 0 && val_q.size() == 0 && dec_q.size() == 0;
  endfunction

  task automatic check_word(input string name, input logic [64:0] actual,
                            input logic [64:0] expected);
    assert (actual === expected) else begin
      $display("[ERROR] %s expected tdata=%h eot=%h actual tdata=%h eot=%h",
               name, expected[64:1], expected[0], actual[64:1], actual[0]);
      mon_err_cnt++;
    end
  endtask

  task automatic report_extra(input string name, input logic [64:0] actual);
    $display("Unexpected word popped from %s while nothing was expected, value %h",
             name, actual);
    mon_err_cnt++;
  endtask

  // Steering rule: eng_id bit 2 low goes to the encrypt/validate pair
  task automatic push_expected(input logic to_dec, input logic [64:0] word);
    if (to_dec) begin
      dec_q.push_back(word);
    end else begin
      enc_q.push_back(word);
      val_q.push_back(word);
    end
  endtask

  task automatic load_keys();
    logic [KME_DATA_W-1:0] word;
    int                    a;
    for (a = 0; a < KME_CKV_DEPTH; a++) begin
      rng_state    = xorshift32(rng_state);
      word[63:32]  = rng_state;
      rng_state    = xorshift32(rng_state);
      word[31:0]   = rng_state;
      key_mirror[a] = word;
      key_wr      <= 1'b1;
      key_wr_addr <= KME_CKV_AW'(a);
      key_wr_data <= word;
      @(posedge clk);
    end
    key_wr <= 1'b0;
  endtask

  // Waits for the reader to go idle, then strobes one command
  task automatic issue_cmd(input logic [3:0] eng, input logic [3:0] idx);
    int          cycles;
    int          w;
    logic [64:0] word;
    cycles = 0;
    @(posedge clk);
    while (busy && cycles < IDLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    if (busy) begin
      $display("Timeout: reader stayed busy, command for key slot %0d not issued", idx);
      seq_err_cnt++;
    end else begin
      // Header word, never the last of the frame
      word = {KME_TLV_KEY_TYPE, eng, 4'h0, idx, 8'(KME_FRAME_WORDS), 36'h0, 1'b0};
      push_expected(eng[2], word);
      for (w = 0; w < KME_KEY_WORDS; w++) begin
        word = {key_mirror[{idx, KME_WORD_AW'(w)}], (w == KME_KEY_WORDS - 1)};
        push_expected(eng[2], word);
      end
      cmd_valid     <= 1'b1;
      cmd_eng_id    <= eng;
      cmd_key_index <= idx;
      @(posedge clk);
      cmd_valid     <= 1'b0;
    end
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    @(posedge clk);
    while (!all_idle() && cycles < DRAIN_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    if (!all_idle()) begin
      $display("Timeout: frames did not drain from the engine FIFOs");
      seq_err_cnt++;
    end
  endtask

  // ------------------------------------------------------------------------
  // Engine side monitor and pop driver
  // ------------------------------------------------------------------------

  // A word leaves a FIFO on an edge where pop is high and empty is low
  always @(posedge clk) begin
    if (rst_n) begin
      if (encrypt_pop && !encrypt_empty) begin
        if (enc_q.size() == 0) report_extra("encrypt_data", encrypt_data);
        else check_word("encrypt_data", encrypt_data, enc_q.pop_front());
      end
      if (validate_pop && !validate_empty) begin
        if (val_q.size() == 0) report_extra("validate_data", validate_data);
        else check_word("validate_data", validate_data, val_q.pop_front());
      end
      if (decrypt_pop && !decrypt_empty) begin
        if (dec_q.size() == 0) report_extra("decrypt_data", decrypt_data);
        else check_word("decrypt_data", decrypt_data, dec_q.pop_front());
      end
      pop_rng = xorshift32(pop_rng);
      case (pop_mode)
        2'd1: begin
          encrypt_pop  <= 1'b1;
          validate_pop <= 1'b1;
          decrypt_pop  <= 1'b1;
        end
        // Each engine pops on about three cycles out of four
        2'd2: begin
          encrypt_pop  <= (pop_rng[1:0] != 2'b00);
          validate_pop <= (pop_rng[3:2] != 2'b00);
          decrypt_pop  <= (pop_rng[5:4] != 2'b00);
        end
        default: begin
          encrypt_pop  <= 1'b0;
          validate_pop <= 1'b0;
          decrypt_pop  <= 1'b0;
        end
      endcase
    end
  end

  // ------------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------------

  initial begin
    int n;
    int total;
    rng_state     = SEED;
    rst_n         = 1'b0;
    key_wr        = 1'b0;
    key_wr_addr   = '0;
    key_wr_data   = '0;
    cmd_valid     = 1'b0;
    cmd_eng_id    = '0;
    cmd_key_index = '0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    // Reset levels
    assert (!busy && encrypt_empty && validate_empty && decrypt_empty) else begin
      $display("[ERROR] after reset busy=%h encrypt_empty=%h validate_empty=%h decrypt_empty=%h",
               busy, encrypt_empty, validate_empty, decrypt_empty);
      seq_err_cnt++;
    end

    load_keys();
    pop_mode <= 2'd1;

    // One frame to the encrypt/validate pair
    rng_state = xorshift32(rng_state);
    issue_cmd(rng_state[3:0] & 4'b1011, rng_state[7:4]);
    wait_drain();

    // One frame to decrypt
    rng_state = xorshift32(rng_state);
    issue_cmd(rng_state[3:0] | 4'b0100, rng_state[7:4]);
    wait_drain();

    // No pops, third frame fills the encrypt and validate FIFOs
    pop_mode <= 2'd0;
    rng_state = xorshift32(rng_state);
    issue_cmd(4'h1, rng_state[3:0]);
    issue_cmd(4'h6, rng_state[7:4]);
    issue_cmd(4'h3, rng_state[11:8]);
    repeat (HOLD_CYCLES) @(posedge clk);
    assert (busy) else begin
      $display("[ERROR] busy expected 1 actual %h with the FIFOs full", busy);
      seq_err_cnt++;
    end
    pop_mode <= 2'd1;
    wait_drain();

    // Random mix of both paths under random back-pressure
    pop_mode <= 2'd2;
    for (n = 0; n < RANDOM_CMDS; n++) begin
      rng_state = xorshift32(rng_state);
      issue_cmd(rng_state[3:0], rng_state[7:4]);
    end
    wait_drain();

    total = mon_err_cnt + seq_err_cnt + kme_core_inst.u_kop_assigner.u_kop_assert.fail_cnt;
    $display("Errors: %0d data, %0d sequence, %0d assertion", mon_err_cnt, seq_err_cnt,
             kme_core_inst.u_kop_assigner.u_kop_assert.fail_cnt);
    if (total == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== files.f ====
kme_pkg.sv
kme_ckv_ram.sv
kme_ckv_reader.sv
kme_kop_assigner.sv
kme_engine_fifo.sv
kme_core.sv
kme_core_assert.sv
tb_kme_core.sv

// ==== Makefile ====
TOP := tb_kme_core

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

# Output goes to the terminal on stderr while grep decides the status
test:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -f files.f --Mdir obj_dir -o sim
	./obj_dir/sim +verilator+error+limit+1000 | tee /dev/stderr | \
		grep "TESTBENCH PASSED" > /dev/null

clean:
	rm -rf obj_dir
